// ==== src/rate_bridge_pkg.sv ====
package rate_bridge_pkg;

	// per-slot widths on the full-rate AFI side
	localparam int AFI_ADDRESS_WIDTH     = 14;
	localparam int AFI_BANK_WIDTH        = 3;
	localparam int AFI_CHIP_SELECT_WIDTH = 1;
	localparam int AFI_CLK_EN_WIDTH      = 1;
	localparam int AFI_ODT_WIDTH         = 1;
	localparam int AFI_CONTROL_WIDTH     = 1;
	localparam int AFI_DATA_WIDTH        = 16;
	localparam int AFI_DQS_WIDTH         = 2;
	localparam int AFI_DATA_MASK_WIDTH   = 2;

	// a half-rate read word carries two full-rate beats
	localparam int SEQ_DATA_WIDTH        = 2 * AFI_DATA_WIDTH;

	// one full-rate command slot as the PHY sees it
	typedef struct packed {
		logic [AFI_ADDRESS_WIDTH-1:0]     address;
		logic [AFI_BANK_WIDTH-1:0]        bank;
		logic [AFI_CHIP_SELECT_WIDTH-1:0] cs_n;
		logic [AFI_CLK_EN_WIDTH-1:0]      cke;
		logic [AFI_ODT_WIDTH-1:0]         odt;
		logic [AFI_CONTROL_WIDTH-1:0]     ras_n;
		logic [AFI_CONTROL_WIDTH-1:0]     cas_n;
		logic [AFI_CONTROL_WIDTH-1:0]     we_n;
		logic                             rdata_en;
	} afi_cmd_t;

	// lo is the slot that goes out first
	typedef struct packed {
		afi_cmd_t hi;
		afi_cmd_t lo;
	} seq_cmd_t;

	typedef struct packed {
		logic [AFI_DQS_WIDTH-1:0]       dqs_en;
		logic [AFI_DATA_WIDTH-1:0]      wdata;
		logic [AFI_DQS_WIDTH-1:0]       wdata_valid;
		logic [AFI_DATA_MASK_WIDTH-1:0] dm;
	} afi_wr_t;

	typedef struct packed {
		afi_wr_t hi;
		afi_wr_t lo;
	} seq_wr_t;

	// which pair of delayed beats forms the current half-rate word
	typedef enum logic {
		ALIGN_EVEN = 1'b0,
		ALIGN_ODD  = 1'b1
	} align_state_t;

	// a deselected slot with all active-low controls released
	localparam afi_cmd_t AFI_CMD_IDLE = '{
		address:  '0,
		bank:     '0,
		cs_n:     '1,
		cke:      '0,
		odt:      '0,
		ras_n:    '1,
		cas_n:    '1,
		we_n:     '1,
		rdata_en: 1'b0
	};

endpackage

// ==== src/afi_cmd_serializer.sv ====
`timescale 1ns/1ps

module afi_cmd_serializer
	import rate_bridge_pkg::*;
(
	input  logic     seq_clk,
	input  logic     reset_n_seq_clk,
	input  logic     addr_cmd_shift,
	input  seq_cmd_t seq_cmd,
	output afi_cmd_t mux_cmd
);

	// hi slot of the previous half-rate cycle
	afi_cmd_t hi_r;

	// slot shown while seq_clk is high, and the one shown while it is low
	afi_cmd_t early_slot;
	afi_cmd_t late_slot;

	// the delayed hi slot must not issue anything right after reset
	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (!reset_n_seq_clk)
		begin
			hi_r <= AFI_CMD_IDLE;
		end
		else
		begin
			hi_r <= seq_cmd.hi;
		end
	end

	// with the shift on, every slot moves half a seq_clk cycle later
	// so the current lo slot lands in the low phase and the current
	// hi slot waits for the high phase of the next cycle
	always_comb
	begin
		if (addr_cmd_shift)
		begin
			early_slot = hi_r;
			late_slot  = seq_cmd.lo;
		end
		else
		begin
			early_slot = seq_cmd.lo;
			late_slot  = seq_cmd.hi;
		end
	end

	// seq_clk itself picks the phase since afi_clk edges line up with both of its edges
	always_comb
	begin
		if (seq_clk)
		begin
			mux_cmd = early_slot;
		end
		else
		begin
			mux_cmd = late_slot;
		end
	end

	// the shift is a static strap and may only change while reset is held
	property p_shift_static;
		@(posedge seq_clk) disable iff (!reset_n_seq_clk)
		$past(reset_n_seq_clk) |-> $stable(addr_cmd_shift);
	endproperty

	a_shift_static: assert property (p_shift_static)
	else
		$error("addr_cmd_shift changed while out of reset");

endmodule

// ==== src/afi_wdata_serializer.sv ====
`timescale 1ns/1ps

module afi_wdata_serializer
	import rate_bridge_pkg::*;
(
	input  logic    seq_clk,
	input  logic    reset_n_seq_clk,
	input  seq_wr_t seq_wr,
	output afi_wr_t mux_wr
);

	// write data never takes the command shift so lo always goes out first
	always_comb
	begin
		if (seq_clk)
		begin
			mux_wr = seq_wr.lo;
		end
		else
		begin
			mux_wr = seq_wr.hi;
		end
	end

	// a valid write beat on a dqs group needs that group's strobe enabled
	property p_valid_has_dqs(afi_wr_t slot);
		@(posedge seq_clk) disable iff (!reset_n_seq_clk)
		(slot.wdata_valid & ~slot.dqs_en) == '0;
	endproperty

	a_lo_valid_has_dqs: assert property (p_valid_has_dqs(seq_wr.lo))
	else
		$error("lo write slot has wdata_valid without dqs_en");

	a_hi_valid_has_dqs: assert property (p_valid_has_dqs(seq_wr.hi))
	else
		$error("hi write slot has wdata_valid without dqs_en");

endmodule

// ==== src/afi_rdata_deserializer.sv ====
`timescale 1ns/1ps

module afi_rdata_deserializer
	import rate_bridge_pkg::*;
(
	input  logic                      afi_clk,
	input  logic                      reset_n_afi_clk,
	input  logic                      seq_clk,
	input  logic                      reset_n_seq_clk,
	input  logic [AFI_DATA_WIDTH-1:0] mux_rdata,
	input  logic                      mux_rdata_valid,
	output logic [SEQ_DATA_WIDTH-1:0] seq_rdata,
	output logic                      seq_rdata_valid
);

	// two full-rate beats of history
	logic [AFI_DATA_WIDTH-1:0] mux_rdata_r;
	logic [AFI_DATA_WIDTH-1:0] mux_rdata_rr;
	logic                      mux_rdata_valid_r;
	logic                      mux_rdata_valid_rr;

	// burst start seen in the current or the previous beat
	logic                      start_even;
	logic                      start_odd;

	align_state_t              align_state;
	align_state_t              align_sel;

	always_ff @(posedge afi_clk)
	begin
		mux_rdata_r  <= mux_rdata;
		mux_rdata_rr <= mux_rdata_r;
	end

	always_ff @(posedge afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			mux_rdata_valid_r  <= 1'b0;
			mux_rdata_valid_rr <= 1'b0;
		end
		else
		begin
			mux_rdata_valid_r  <= mux_rdata_valid;
			mux_rdata_valid_rr <= mux_rdata_valid_r;
		end
	end

	// burst opened one beat ago, so the current beat closes its first pair
	assign start_even = mux_rdata_valid & mux_rdata_valid_r & ~mux_rdata_valid_rr;

	// burst opens on the current beat, its first pair completes next cycle
	assign start_odd  = mux_rdata_valid & ~mux_rdata_valid_r & ~mux_rdata_valid_rr;

	always_ff @(posedge seq_clk or negedge reset_n_seq_clk)
	begin
		if (!reset_n_seq_clk)
		begin
			align_state <= ALIGN_EVEN;
		end
		else if (start_even)
		begin
			align_state <= ALIGN_EVEN;
		end
		else if (start_odd)
		begin
			align_state <= ALIGN_ODD;
		end
	end

	// a start seen in this cycle takes effect before the register catches up
	always_comb
	begin
		if (start_even)
		begin
			align_sel = ALIGN_EVEN;
		end
		else if (start_odd)
		begin
			align_sel = ALIGN_ODD;
		end
		else
		begin
			align_sel = align_state;
		end
	end

	// the later beat sits in the upper half of the word
	always_comb
	begin
		if (align_sel == ALIGN_ODD)
		begin
			seq_rdata       = {mux_rdata_r, mux_rdata_rr};
			seq_rdata_valid = mux_rdata_valid_r & mux_rdata_valid_rr;
		end
		else
		begin
			seq_rdata       = {mux_rdata, mux_rdata_r};
			seq_rdata_valid = mux_rdata_valid & mux_rdata_valid_r;
		end
	end

	// start detection only works when a burst follows at least two idle beats
	property p_idle_before_burst;
		@(posedge afi_clk) disable iff (!reset_n_afi_clk)
		$rose(mux_rdata_valid) |-> !mux_rdata_valid_rr;
	endproperty

	a_idle_before_burst: assert property (p_idle_before_burst)
	else
		$error("read burst started with fewer than two idle beats before it");

endmodule

// ==== src/rate_bridge_top.sv ====
`timescale 1ns/1ps

module rate_bridge_top
	import rate_bridge_pkg::*;
(
	input  logic                      seq_clk,
	input  logic                      reset_n_seq_clk,
	input  logic                      afi_clk,
	input  logic                      reset_n_afi_clk,

	// static level, selects the half-cycle command shift
	input  logic                      addr_cmd_shift,

	// half-rate side towards the calibration sequencer
	input  seq_cmd_t                  seq_cmd,
	input  seq_wr_t                   seq_wr,
	output logic [SEQ_DATA_WIDTH-1:0] seq_rdata,
	output logic                      seq_rdata_valid,

	// full-rate side towards the PHY
	output afi_cmd_t                  mux_cmd,
	output afi_wr_t                   mux_wr,
	input  logic [AFI_DATA_WIDTH-1:0] mux_rdata,
	input  logic                      mux_rdata_valid
);

	// address and command path
	afi_cmd_serializer cmd_ser_i (
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.addr_cmd_shift  (addr_cmd_shift),
		.seq_cmd         (seq_cmd),
		.mux_cmd         (mux_cmd)
	);

	// write data, mask, dqs enable and write valid
	afi_wdata_serializer wr_ser_i (
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.seq_wr          (seq_wr),
		.mux_wr          (mux_wr)
	);

	// read beats cross from afi_clk into half-rate words
	afi_rdata_deserializer rd_des_i (
		.afi_clk         (afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.mux_rdata       (mux_rdata),
		.mux_rdata_valid (mux_rdata_valid),
		.seq_rdata       (seq_rdata),
		.seq_rdata_valid (seq_rdata_valid)
	);

endmodule

// ==== tb/rate_bridge_model.svh ====
`ifndef RATE_BRIDGE_MODEL_SVH
`define RATE_BRIDGE_MODEL_SVH

// read words the bridge still owes, in burst order
logic [SEQ_DATA_WIDTH-1:0] rd_expect_q[$];

// a deselected slot, every active-low control released
function automatic afi_cmd_t inactive_cmd();
	afi_cmd_t slot;
	slot       = '0;
	slot.cs_n  = '1;
	slot.ras_n = '1;
	slot.cas_n = '1;
	slot.we_n  = '1;
	return slot;
endfunction

// prev_hi is the hi slot of the word from the previous cycle
function automatic afi_cmd_t expected_cmd(
	input logic     shift,
	input logic     high_phase,
	input seq_cmd_t cur,
	input afi_cmd_t prev_hi
);
	if (shift)
	begin
		return high_phase ? prev_hi : cur.lo;
	end
	return high_phase ? cur.lo : cur.hi;
endfunction

function automatic afi_wr_t expected_wr(input logic high_phase, input seq_wr_t cur);
	return high_phase ? cur.lo : cur.hi;
endfunction

// the later beat of a pair fills the upper half
function automatic logic [SEQ_DATA_WIDTH-1:0] read_word(
	input logic [AFI_DATA_WIDTH-1:0] first,
	input logic [AFI_DATA_WIDTH-1:0] second
);
	return {second, first};
endfunction

`endif

// ==== tb/rate_bridge_tb.sv ====
`timescale 1ns/1ps

module rate_bridge_tb
	import rate_bridge_pkg::*;
;

	localparam int RESET_CYCLES   = 3;
	localparam int PHASE_CYCLES   = 300;
	localparam int DRAIN_CYCLES   = 10;
	localparam int TEST_CYCLES    = 2 * (1 + RESET_CYCLES + PHASE_CYCLES + DRAIN_CYCLES);
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + 50;
	// leaves room for the longest burst and gap before the phase ends
	localparam int READ_BEATS     = 2 * PHASE_CYCLES - 16;

	logic                      seq_clk = 1'b0;
	// starts high so its rising edges meet those of seq_clk
	logic                      afi_clk = 1'b1;
	logic                      reset_n_seq_clk;
	logic                      reset_n_afi_clk;
	logic                      addr_cmd_shift;
	seq_cmd_t                  seq_cmd;
	seq_wr_t                   seq_wr;
	afi_cmd_t                  mux_cmd;
	afi_wr_t                   mux_wr;
	logic [AFI_DATA_WIDTH-1:0] mux_rdata;
	logic                      mux_rdata_valid;
	logic [SEQ_DATA_WIDTH-1:0] seq_rdata;
	logic                      seq_rdata_valid;

	int value_errors = 0;
	int other_errors = 0;
	int cycle_count  = 0;

	`include "rate_bridge_model.svh"

	rate_bridge_top dut_i (
		.seq_clk         (seq_clk),
		.reset_n_seq_clk (reset_n_seq_clk),
		.afi_clk         (afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.addr_cmd_shift  (addr_cmd_shift),
		.seq_cmd         (seq_cmd),
		.seq_wr          (seq_wr),
		.seq_rdata       (seq_rdata),
		.seq_rdata_valid (seq_rdata_valid),
		.mux_cmd         (mux_cmd),
		.mux_wr          (mux_wr),
		.mux_rdata       (mux_rdata),
		.mux_rdata_valid (mux_rdata_valid)
	);

	initial
	begin
		forever #50 seq_clk = ~seq_clk;
	end

	initial
	begin
		forever #25 afi_clk = ~afi_clk;
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error at %0t ns: %s expected %h, actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic print_summary();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
	endtask

	function automatic seq_cmd_t random_cmd();
		logic [63:0] bits;
		bits = {$urandom, $urandom};
		return bits[$bits(seq_cmd_t)-1:0];
	endfunction

	function automatic afi_wr_t random_wr_slot();
		afi_wr_t     slot;
		logic [31:0] bits;
		bits = $urandom;
		slot = bits[$bits(afi_wr_t)-1:0];
		// a valid beat always comes with its strobe enabled
		slot.dqs_en = slot.dqs_en | slot.wdata_valid;
		return slot;
	endfunction

	task automatic apply_reset(input logic shift);
		@(posedge seq_clk);
		reset_n_seq_clk <= 1'b0;
		reset_n_afi_clk <= 1'b0;
		addr_cmd_shift  <= shift;
		repeat (RESET_CYCLES)
		begin
			@(posedge seq_clk);
			seq_cmd <= random_cmd();
		end
		reset_n_seq_clk <= 1'b1;
		reset_n_afi_clk <= 1'b1;
	endtask

	// checks in the middle of the high phase, then of the low phase
	task automatic drive_bridge(input int cycles);
		seq_cmd_t cur_cmd;
		seq_wr_t  cur_wr;
		afi_cmd_t prev_hi;
		prev_hi = inactive_cmd();
		for (int i = 0; i < cycles; i++)
		begin
			cur_cmd = random_cmd();
			cur_wr  = {random_wr_slot(), random_wr_slot()};
			seq_cmd <= cur_cmd;
			seq_wr  <= cur_wr;
			#25;
			if (addr_cmd_shift && i == 0)
			begin
				check_value("mux_cmd after reset", 64'(inactive_cmd()), 64'(mux_cmd));
			end
			else
			begin
				check_value("mux_cmd high phase",
					64'(expected_cmd(addr_cmd_shift, 1'b1, cur_cmd, prev_hi)), 64'(mux_cmd));
			end
			check_value("mux_wr high phase", 64'(expected_wr(1'b1, cur_wr)), 64'(mux_wr));
			#50;
			check_value("mux_cmd low phase",
				64'(expected_cmd(addr_cmd_shift, 1'b0, cur_cmd, prev_hi)), 64'(mux_cmd));
			check_value("mux_wr low phase", 64'(expected_wr(1'b0, cur_wr)), 64'(mux_wr));
			prev_hi = cur_cmd.hi;
			@(posedge seq_clk);
		end
	endtask

	task automatic drive_reads(input int beat_budget);
		logic [AFI_DATA_WIDTH-1:0] burst[$];
		int                        used;
		int                        len;
		int                        gap;
		used = 0;
		while (used + 13 <= beat_budget)
		begin
			gap = 2 + int'($urandom % 4);
			repeat (gap)
			begin
				@(posedge afi_clk);
				mux_rdata_valid <= 1'b0;
				mux_rdata       <= AFI_DATA_WIDTH'($urandom);
			end
			len = 2 << ($urandom % 3);
			burst.delete();
			for (int b = 0; b < len; b++)
			begin
				burst.push_back(AFI_DATA_WIDTH'($urandom));
				if (b % 2 == 1)
				begin
					rd_expect_q.push_back(read_word(burst[b-1], burst[b]));
				end
			end
			foreach (burst[b])
			begin
				@(posedge afi_clk);
				mux_rdata_valid <= 1'b1;
				mux_rdata       <= burst[b];
			end
			used += gap + len;
		end
		@(posedge afi_clk);
		mux_rdata_valid <= 1'b0;
	endtask

	task automatic run_phase(input logic shift);
		apply_reset(shift);
		fork
			drive_bridge(PHASE_CYCLES);
			drive_reads(READ_BEATS);
		join
		repeat (DRAIN_CYCLES) @(posedge seq_clk);
		if (rd_expect_q.size() != 0)
		begin
			other_errors++;
			$display("%0d read words were never delivered", rd_expect_q.size());
			rd_expect_q.delete();
		end
	endtask

	// read words are stable from the afi edge in the low phase up to the next seq_clk rise
	initial
	begin
		logic [SEQ_DATA_WIDTH-1:0] want;
		forever
		begin
			@(posedge seq_clk);
			#75;
			if (reset_n_seq_clk === 1'b1 && seq_rdata_valid !== 1'b0)
			begin
				if (rd_expect_q.size() == 0)
				begin
					other_errors++;
					$display("read word %h at %0t ns arrived with no burst left to pair",
						seq_rdata, $time);
				end
				else
				begin
					want = rd_expect_q.pop_front();
					check_value("seq_rdata", 64'(want), 64'(seq_rdata));
				end
			end
		end
	end

	initial
	begin
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge seq_clk);
			cycle_count++;
		end
		$display("run timed out after %0d seq_clk cycles", cycle_count);
		print_summary();
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hce4a0a7d));
		reset_n_seq_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		addr_cmd_shift  = 1'b0;
		seq_cmd         = '0;
		seq_wr          = '0;
		mux_rdata       = '0;
		mux_rdata_valid = 1'b0;
		run_phase(1'b0);
		run_phase(1'b1);
		print_summary();
		if (value_errors == 0 && other_errors == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+tb
src/rate_bridge_pkg.sv
src/afi_cmd_serializer.sv
src/afi_wdata_serializer.sv
src/afi_rdata_deserializer.sv
src/rate_bridge_top.sv
tb/rate_bridge_tb.sv
